// File: Bender.yml
package:
  name: warp_scheduler

sources:
  - warp_sched_pkg.sv
  - warp_state.sv
  - barrier_table.sv
  - warp_select.sv
  - fetch_buffer.sv
  - pending_tracker.sv
  - warp_scheduler.sv
  - target: test
    files:
      - warp_scheduler_sva.sv
      - tb_warp_scheduler.sv

// File: barrier_table.sv
// local barrier arrival counters, waiting masks and release decision
`timescale 1ns/1ps
`default_nettype none

module barrier_table import warp_sched_pkg::*; (
    input  wire            clk,
    input  wire            reset,
    input  wire warp_ctl_t warp_ctl,
    output barrier_rel_t   barrier_rel
);

    wid_t   [NUM_BARRIERS-1:0] count_q;
    wmask_t [NUM_BARRIERS-1:0] waiting_q;

    bar_id_t bar_id;
    wmask_t  wid_bit;
    logic    arrive;
    logic    release_hit;

    assign bar_id  = warp_ctl.barrier.id;
    assign wid_bit = wmask_t'(1) << warp_ctl.wid;
    assign arrive  = warp_ctl.valid && warp_ctl.barrier.valid;

    // last arrival when count already equals size_m1
    assign release_hit = arrive && (count_q[bar_id] == warp_ctl.barrier.size_m1);

    always_comb begin
        barrier_rel.valid = release_hit;
        // waiting warps plus the one that completes the barrier
        barrier_rel.wmask = waiting_q[bar_id] | wid_bit;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            count_q   <= '0;
            waiting_q <= '0;
        end else begin
            if (release_hit) begin
                count_q[bar_id]   <= '0;
                waiting_q[bar_id] <= '0;
            end else if (arrive) begin
                count_q[bar_id]   <= count_q[bar_id] + wid_t'(1);
                waiting_q[bar_id] <= waiting_q[bar_id] | wid_bit;
            end
        end
    end

endmodule

`default_nettype wire

// File: fetch_buffer.sv
// two-entry valid/ready buffer with registered output toward fetch
`timescale 1ns/1ps
`default_nettype none

module fetch_buffer import warp_sched_pkg::*; (
    input  wire               clk,
    input  wire               reset,
    input  wire sched_entry_t in_entry,
    input  wire               in_valid,
    output logic              in_ready,
    output sched_entry_t      out_entry,
    output logic              out_valid,
    input  wire               out_ready
);

    // second slot, only filled while the output is stalled
    sched_entry_t skid_entry;
    logic         skid_valid;
    logic         out_load;
    logic         in_fire;

    assign in_ready = !skid_valid;
    assign in_fire  = in_valid && in_ready;
    assign out_load = out_ready || !out_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid  <= 1'b0;
            skid_valid <= 1'b0;
        end else begin
            if (out_load) begin
                // older skid entry goes first
                out_valid  <= skid_valid || in_fire;
                skid_valid <= 1'b0;
            end else if (in_fire) begin
                skid_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (out_load) begin
            if (skid_valid) begin
                out_entry <= skid_entry;
            end else if (in_fire) begin
                out_entry <= in_entry;
            end
        end else if (in_fire) begin
            skid_entry <= in_entry;
        end
    end

endmodule

`default_nettype wire

// File: pending_tracker.sv
// per-warp in-flight instruction counters and registered busy flag
`timescale 1ns/1ps
`default_nettype none

module pending_tracker import warp_sched_pkg::*; (
    input  wire         clk,
    input  wire         reset,
    input  wire         issue_valid,
    input  wire wid_t   issue_wid,
    input  wire wmask_t commit_warps,
    input  wire wmask_t active_warps,
    output logic        busy
);

    logic [NUM_WARPS-1:0][PENDING_BITS-1:0] count_q;
    wmask_t                                 nonzero;

    for (genvar i = 0; i < NUM_WARPS; i++) begin : g_counter
        logic incr;
        logic decr;

        assign incr       = issue_valid && (issue_wid == wid_t'(i));
        assign decr       = commit_warps[i];
        assign nonzero[i] = (count_q[i] != '0);

        // saturating, simultaneous issue and commit cancel out
        always_ff @(posedge clk) begin
            if (reset) begin
                count_q[i] <= '0;
            end else if (incr && !decr && (count_q[i] != '1)) begin
                count_q[i] <= count_q[i] + 1'b1;
            end else if (decr && !incr && nonzero[i]) begin
                count_q[i] <= count_q[i] - 1'b1;
            end
        end
    end

    // reports busy out of reset
    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b1;
        end else begin
            busy <= (active_warps != '0) || (nonzero != '0);
        end
    end

endmodule

`default_nettype wire

// File: sim.f
warp_sched_pkg.sv
warp_state.sv
barrier_table.sv
warp_select.sv
fetch_buffer.sv
pending_tracker.sv
warp_scheduler.sv
warp_scheduler_sva.sv
tb_warp_scheduler.sv

// File: tb_warp_scheduler.sv
// directed warp scheduler testbench with clock, reset, stimulus tasks, checks and timeout
`timescale 1ns/1ps
`default_nettype none

module tb_warp_scheduler import warp_sched_pkg::*; ();

    localparam pc_t STARTUP_PC     = pc_t'('h200);
    localparam int  TEST_CYCLES    = 400;
    localparam int  TIMEOUT_CYCLES = 5 * TEST_CYCLES;
    localparam int  WAIT_LIMIT     = 50;

    logic         clk;
    logic         reset;
    warp_ctl_t    warp_ctl;
    branch_t      branch;
    logic         decode_unlock;
    wid_t         decode_wid;
    logic         issue_valid;
    wid_t         issue_wid;
    wmask_t       commit_warps;
    sched_entry_t sched;
    logic         sched_valid;
    logic         sched_ready;
    logic         busy;

    // pc that each warp's next entry should carry
    pc_t exp_pc [NUM_WARPS];
    int  seed_ret;
    int  cycle_count;

    warp_scheduler #(
        .STARTUP_PC (STARTUP_PC)
    ) i_dut (
        .clk           (clk),
        .reset         (reset),
        .warp_ctl      (warp_ctl),
        .branch        (branch),
        .decode_unlock (decode_unlock),
        .decode_wid    (decode_wid),
        .issue_valid   (issue_valid),
        .issue_wid     (issue_wid),
        .commit_warps  (commit_warps),
        .sched         (sched),
        .sched_valid   (sched_valid),
        .sched_ready   (sched_ready),
        .busy          (busy)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    task automatic abort_run();
        $display("=== FAIL ===");
        $fatal(1, "run stopped at first error");
    endtask

    function automatic sched_entry_t make_entry(input wid_t wid, input tmask_t tmask,
                                                input pc_t pc);
        sched_entry_t e;
        e.wid   = wid;
        e.tmask = tmask;
        e.pc    = pc;
        return e;
    endfunction

    task automatic check_entry(input sched_entry_t got, input sched_entry_t exp,
                               input string what);
        if (got !== exp) begin
            $display("[FAIL] %0t %s: got wid %0d tmask %b pc %h", $time, what,
                     got.wid, got.tmask, got.pc);
            $display("[FAIL] %0t %s: expected wid %0d tmask %b pc %h", $time, what,
                     exp.wid, exp.tmask, exp.pc);
            abort_run();
        end
    endtask

    task automatic check_busy(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("[FAIL] %0t %s: busy is %b, expected %b", $time, what, got, exp);
            abort_run();
        end
    endtask

    // takes one entry from fetch and returns at the falling edge after the transfer
    task automatic get_entry(output sched_entry_t e);
        int waited;
        waited      = 0;
        sched_ready = 1'b1;
        while (!sched_valid) begin
            @(negedge clk);
            waited++;
            if (waited > WAIT_LIMIT) begin
                $display("no entry reached fetch within %0d cycles", WAIT_LIMIT);
                abort_run();
            end
        end
        e = sched;
        @(negedge clk);
        sched_ready = 1'b0;
    endtask

    task automatic expect_entry(input wid_t wid, input tmask_t tmask, input pc_t pc,
                                input string what);
        sched_entry_t got;
        get_entry(got);
        check_entry(got, make_entry(wid, tmask, pc), what);
    endtask

    task automatic expect_idle(input int cycles, input string what);
        sched_ready = 1'b1;
        repeat (cycles) begin
            @(negedge clk);
            if (sched_valid) begin
                $display("[FAIL] %0t %s: unexpected entry for wid %0d", $time, what,
                         sched.wid);
                abort_run();
            end
        end
        sched_ready = 1'b0;
    endtask

    task automatic send_unlock(input wid_t wid);
        decode_unlock = 1'b1;
        decode_wid    = wid;
        @(negedge clk);
        decode_unlock = 1'b0;
    endtask

    task automatic send_branch(input wid_t wid, input logic taken, input pc_t dest);
        branch.valid = 1'b1;
        branch.wid   = wid;
        branch.taken = taken;
        branch.dest  = dest;
        @(negedge clk);
        branch = '0;
    endtask

    task automatic send_ctl(input warp_ctl_t ctl);
        warp_ctl = ctl;
        @(negedge clk);
        warp_ctl = '0;
    endtask

    function automatic warp_ctl_t tmc_cmd(input wid_t wid, input tmask_t tmask);
        warp_ctl_t c;
        c           = '0;
        c.valid     = 1'b1;
        c.wid       = wid;
        c.tmc.valid = 1'b1;
        c.tmc.tmask = tmask;
        return c;
    endfunction

    function automatic warp_ctl_t barrier_cmd(input wid_t wid, input bar_id_t id,
                                              input wid_t size_m1);
        warp_ctl_t c;
        c                 = '0;
        c.valid           = 1'b1;
        c.wid             = wid;
        c.barrier.valid   = 1'b1;
        c.barrier.id      = id;
        c.barrier.size_m1 = size_m1;
        return c;
    endfunction

    task automatic test_startup();
        expect_entry(wid_t'(0), tmask_t'(1), STARTUP_PC, "startup entry");
        exp_pc[0] = STARTUP_PC + pc_t'(1);
        check_busy(busy, 1'b1, "busy after reset");
    endtask

    task automatic test_sequential();
        sched_entry_t held;
        for (int i = 0; i < 4; i++) begin
            send_unlock(wid_t'(0));
            expect_entry(wid_t'(0), tmask_t'(1), exp_pc[0], "sequential entry");
            exp_pc[0] = exp_pc[0] + pc_t'(1);
        end
        // fetch holds ready low for a while
        send_unlock(wid_t'(0));
        repeat (6) @(negedge clk);
        if (!sched_valid) begin
            $display("entry missing while fetch held ready low");
            abort_run();
        end
        held = sched;
        check_entry(held, make_entry(wid_t'(0), tmask_t'(1), exp_pc[0]), "held entry");
        expect_entry(wid_t'(0), tmask_t'(1), exp_pc[0], "entry after back-pressure");
        exp_pc[0] = exp_pc[0] + pc_t'(1);
        expect_idle(5, "duplicate after back-pressure");
    endtask

    task automatic test_branch();
        pc_t dest;
        dest = pc_t'($urandom);
        send_branch(wid_t'(0), 1'b1, dest);
        expect_entry(wid_t'(0), tmask_t'(1), dest, "taken branch target");
        exp_pc[0] = dest + pc_t'(1);
        send_branch(wid_t'(0), 1'b0, pc_t'($urandom));
        expect_entry(wid_t'(0), tmask_t'(1), exp_pc[0], "not-taken fall-through");
        exp_pc[0] = exp_pc[0] + pc_t'(1);
    endtask

    task automatic test_spawn_tmc();
        pc_t       spawn_pc;
        warp_ctl_t ctl;
        spawn_pc           = pc_t'($urandom);
        ctl                = '0;
        ctl.valid          = 1'b1;
        ctl.wid            = wid_t'(0);
        ctl.wspawn.valid   = 1'b1;
        ctl.wspawn.wmask   = wmask_t'(4'b1110);
        ctl.wspawn.pc      = spawn_pc;
        send_ctl(ctl);
        // ready stays low so both buffer slots fill
        repeat (8) @(negedge clk);
        // spawning warp is released too and wins as lowest index
        expect_entry(wid_t'(0), tmask_t'(1), exp_pc[0], "spawning warp resumes");
        exp_pc[0] = exp_pc[0] + pc_t'(1);
        for (int w = 1; w < NUM_WARPS; w++) begin
            expect_entry(wid_t'(w), tmask_t'(1), spawn_pc, "spawned warp");
            exp_pc[w] = spawn_pc + pc_t'(1);
        end
        send_ctl(tmc_cmd(wid_t'(2), tmask_t'(4'b0110)));
        expect_entry(wid_t'(2), tmask_t'(4'b0110), exp_pc[2], "tmask after tmc");
        exp_pc[2] = exp_pc[2] + pc_t'(1);
    endtask

    task automatic test_barrier();
        send_ctl(barrier_cmd(wid_t'(0), bar_id_t'(2), wid_t'(1)));
        expect_idle(8, "warp passed barrier early");
        send_ctl(barrier_cmd(wid_t'(1), bar_id_t'(2), wid_t'(1)));
        expect_entry(wid_t'(0), tmask_t'(1), exp_pc[0], "warp 0 after release");
        exp_pc[0] = exp_pc[0] + pc_t'(1);
        expect_entry(wid_t'(1), tmask_t'(1), exp_pc[1], "warp 1 after release");
        exp_pc[1] = exp_pc[1] + pc_t'(1);
    endtask

    task automatic test_busy();
        issue_valid = 1'b1;
        issue_wid   = wid_t'(0);
        @(negedge clk);
        issue_valid = 1'b0;
        for (int w = 0; w < NUM_WARPS; w++) begin
            send_ctl(tmc_cmd(wid_t'(w), tmask_t'(0)));
        end
        repeat (2) @(negedge clk);
        check_busy(busy, 1'b1, "busy with instruction in flight");
        commit_warps = wmask_t'(1);
        @(negedge clk);
        commit_warps = '0;
        @(negedge clk);
        check_busy(busy, 1'b0, "busy after last commit");
        expect_idle(10, "entry from retired warp");
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        abort_run();
    end

    // a failed fetch-side assertion ends the run
    always @(negedge clk) begin
        if (i_dut.i_sva.error_count != 0) begin
            $display("a bound assertion on the fetch interface failed");
            abort_run();
        end
    end

    initial begin
        $timeformat(-9, 0, " ns", 0);
        seed_ret      = $urandom(54);
        reset         = 1'b1;
        warp_ctl      = '0;
        branch        = '0;
        decode_unlock = 1'b0;
        decode_wid    = '0;
        issue_valid   = 1'b0;
        issue_wid     = '0;
        commit_warps  = '0;
        sched_ready   = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        test_startup();
        test_sequential();
        test_branch();
        test_spawn_tmc();
        test_barrier();
        test_busy();

        if (i_dut.i_sva.error_count == 0) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            $display("a bound assertion on the fetch interface failed");
            abort_run();
        end
    end

endmodule

`default_nettype wire

// File: warp_sched_pkg.sv
// warp scheduler sizes, shared struct types and pc step
`default_nettype none

package warp_sched_pkg;

    // core sizes
    localparam int NUM_WARPS    = 4;
    localparam int NUM_THREADS  = 4;
    localparam int NUM_BARRIERS = 4;
    localparam int PC_BITS      = 30;
    localparam int NW_BITS      = (NUM_WARPS > 1) ? $clog2(NUM_WARPS) : 1;
    localparam int NB_BITS      = (NUM_BARRIERS > 1) ? $clog2(NUM_BARRIERS) : 1;
    localparam int PENDING_BITS = 12;

    typedef logic [NW_BITS-1:0]     wid_t;
    typedef logic [NUM_THREADS-1:0] tmask_t;
    typedef logic [PC_BITS-1:0]     pc_t;
    typedef logic [NUM_WARPS-1:0]   wmask_t;
    typedef logic [NB_BITS-1:0]     bar_id_t;

    // pc is word addressed, one instruction per step
    localparam pc_t PC_STEP = pc_t'(1);

    typedef struct packed {
        logic   valid;
        tmask_t tmask;
    } tmc_t;

    typedef struct packed {
        logic   valid;
        wmask_t wmask;
        pc_t    pc;
    } wspawn_t;

    // size_m1 is participating warps minus one
    typedef struct packed {
        logic    valid;
        bar_id_t id;
        wid_t    size_m1;
    } barrier_t;

    // at most one sub-group set per command
    typedef struct packed {
        logic     valid;
        wid_t     wid;
        tmc_t     tmc;
        wspawn_t  wspawn;
        barrier_t barrier;
    } warp_ctl_t;

    typedef struct packed {
        logic valid;
        wid_t wid;
        logic taken;
        pc_t  dest;
    } branch_t;

    typedef struct packed {
        wid_t   wid;
        tmask_t tmask;
        pc_t    pc;
    } sched_entry_t;

    typedef struct packed {
        logic   valid;
        wmask_t wmask;
    } barrier_rel_t;

endpackage

`default_nettype wire

// File: warp_scheduler.sv
// warp scheduler top level connecting state, barriers, select, buffer and tracker
`timescale 1ns/1ps
`default_nettype none

module warp_scheduler import warp_sched_pkg::*; #(
    parameter pc_t STARTUP_PC = pc_t'('h400)
) (
    input  wire               clk,
    input  wire               reset,
    input  wire warp_ctl_t    warp_ctl,
    input  wire branch_t      branch,
    input  wire               decode_unlock,
    input  wire wid_t         decode_wid,
    input  wire               issue_valid,
    input  wire wid_t         issue_wid,
    input  wire wmask_t       commit_warps,
    output sched_entry_t      sched,
    output logic              sched_valid,
    input  wire               sched_ready,
    output logic              busy
);

    wmask_t                 ready_warps;
    wmask_t                 active_warps;
    tmask_t [NUM_WARPS-1:0] all_tmasks;
    pc_t    [NUM_WARPS-1:0] all_pcs;
    barrier_rel_t           barrier_rel;
    sched_entry_t           cand;
    logic                   cand_valid;
    logic                   cand_ready;

    // pick into the buffer, accept out to fetch
    wire pick_fire   = cand_valid && cand_ready;
    wire accept_fire = sched_valid && sched_ready;

    warp_state #(
        .STARTUP_PC (STARTUP_PC)
    ) i_warp_state (
        .clk           (clk),
        .reset         (reset),
        .warp_ctl      (warp_ctl),
        .branch        (branch),
        .decode_unlock (decode_unlock),
        .decode_wid    (decode_wid),
        .barrier_rel   (barrier_rel),
        .pick_fire     (pick_fire),
        .pick_wid      (cand.wid),
        .accept_fire   (accept_fire),
        .accept_entry  (sched),
        .ready_warps   (ready_warps),
        .active_warps  (active_warps),
        .all_tmasks    (all_tmasks),
        .all_pcs       (all_pcs)
    );

    barrier_table i_barrier_table (
        .clk         (clk),
        .reset       (reset),
        .warp_ctl    (warp_ctl),
        .barrier_rel (barrier_rel)
    );

    warp_select i_warp_select (
        .ready_warps (ready_warps),
        .all_tmasks  (all_tmasks),
        .all_pcs     (all_pcs),
        .cand        (cand),
        .cand_valid  (cand_valid)
    );

    fetch_buffer i_fetch_buffer (
        .clk       (clk),
        .reset     (reset),
        .in_entry  (cand),
        .in_valid  (cand_valid),
        .in_ready  (cand_ready),
        .out_entry (sched),
        .out_valid (sched_valid),
        .out_ready (sched_ready)
    );

    pending_tracker i_pending_tracker (
        .clk          (clk),
        .reset        (reset),
        .issue_valid  (issue_valid),
        .issue_wid    (issue_wid),
        .commit_warps (commit_warps),
        .active_warps (active_warps),
        .busy         (busy)
    );

endmodule

`default_nettype wire

// File: warp_scheduler_sva.sv
// fetch-side assertions for the warp scheduler and their bind
`timescale 1ns/1ps
`default_nettype none

module warp_scheduler_sva import warp_sched_pkg::*; (
    input wire               clk,
    input wire               reset,
    input wire sched_entry_t sched,
    input wire               sched_valid,
    input wire               sched_ready
);

    // failed assertions so far, watched by the testbench
    int unsigned error_count = 0;

    // offered entry holds until fetch takes it
    property p_sched_stable;
        @(posedge clk) disable iff (reset)
        sched_valid && !sched_ready |=> sched_valid && $stable(sched);
    endproperty

    property p_valid_low_after_reset;
        @(posedge clk) reset |=> !sched_valid;
    endproperty

    // a warp with no lanes is never scheduled
    property p_tmask_nonzero;
        @(posedge clk) disable iff (reset)
        sched_valid |-> (sched.tmask != '0);
    endproperty

    a_sched_stable: assert property (p_sched_stable)
        else begin
            error_count++;
            $error("sched changed while fetch held ready low");
        end
    a_valid_low_after_reset: assert property (p_valid_low_after_reset)
        else begin
            error_count++;
            $error("sched_valid high in the cycle after reset");
        end
    a_tmask_nonzero: assert property (p_tmask_nonzero)
        else begin
            error_count++;
            $error("sched entry issued with an empty thread mask");
        end

endmodule

bind warp_scheduler warp_scheduler_sva i_sva (
    .clk         (clk),
    .reset       (reset),
    .sched       (sched),
    .sched_valid (sched_valid),
    .sched_ready (sched_ready)
);

`default_nettype wire

// File: warp_select.sv
// lowest-index ready warp picker with tmask and pc select
`timescale 1ns/1ps
`default_nettype none

module warp_select import warp_sched_pkg::*; (
    input  wire wmask_t                 ready_warps,
    input  wire tmask_t [NUM_WARPS-1:0] all_tmasks,
    input  wire pc_t    [NUM_WARPS-1:0] all_pcs,
    output sched_entry_t                cand,
    output logic                        cand_valid
);

    // walk downward so the lowest ready index wins
    always_comb begin
        cand       = '0;
        cand_valid = 1'b0;
        for (int i = NUM_WARPS - 1; i >= 0; i--) begin
            if (ready_warps[i]) begin
                cand.wid   = wid_t'(i);
                cand.tmask = all_tmasks[i];
                cand.pc    = all_pcs[i];
                cand_valid = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: warp_state.sv
// per-warp active, stalled, tmask and pc registers with control event handling
`timescale 1ns/1ps
`default_nettype none

module warp_state import warp_sched_pkg::*; #(
    parameter pc_t STARTUP_PC = '0
) (
    input  wire                         clk,
    input  wire                         reset,
    input  wire warp_ctl_t              warp_ctl,
    input  wire branch_t                branch,
    input  wire                         decode_unlock,
    input  wire wid_t                   decode_wid,
    input  wire barrier_rel_t           barrier_rel,
    input  wire                         pick_fire,
    input  wire wid_t                   pick_wid,
    input  wire                         accept_fire,
    input  wire sched_entry_t           accept_entry,
    output wmask_t                      ready_warps,
    output wmask_t                      active_warps,
    output tmask_t [NUM_WARPS-1:0]      all_tmasks,
    output pc_t    [NUM_WARPS-1:0]      all_pcs
);

    wmask_t                 active_q;
    wmask_t                 active_n;
    wmask_t                 stalled_q;
    wmask_t                 stalled_n;
    tmask_t [NUM_WARPS-1:0] tmasks_q;
    tmask_t [NUM_WARPS-1:0] tmasks_n;
    pc_t    [NUM_WARPS-1:0] pcs_q;
    pc_t    [NUM_WARPS-1:0] pcs_n;

    // pending spawn, held until only one warp runs
    logic   spawn_valid;
    wmask_t spawn_wmask;
    pc_t    spawn_pc;
    wid_t   spawn_wid;
    logic   single_warp;
    logic   spawn_apply;
    logic   spawn_capture;

    assign single_warp   = ($countones(active_q) == 1);
    assign spawn_apply   = spawn_valid && single_warp;
    assign spawn_capture = warp_ctl.valid && warp_ctl.wspawn.valid;

    // later statements override earlier ones
    always_comb begin
        active_n  = active_q;
        stalled_n = stalled_q;
        tmasks_n  = tmasks_q;
        pcs_n     = pcs_q;

        if (decode_unlock) begin
            stalled_n[decode_wid] = 1'b0;
        end

        if (spawn_apply) begin
            active_n = active_n | spawn_wmask;
            for (int i = 0; i < NUM_WARPS; i++) begin
                if (spawn_wmask[i]) begin
                    tmasks_n[i] = tmask_t'(1);
                    pcs_n[i]    = spawn_pc;
                end
            end
            stalled_n[spawn_wid] = 1'b0;
        end

        // thread mask change, zero mask retires the warp
        if (warp_ctl.valid && warp_ctl.tmc.valid) begin
            active_n[warp_ctl.wid]  = (warp_ctl.tmc.tmask != '0);
            tmasks_n[warp_ctl.wid]  = warp_ctl.tmc.tmask;
            stalled_n[warp_ctl.wid] = 1'b0;
        end

        if (barrier_rel.valid) begin
            stalled_n = stalled_n & ~barrier_rel.wmask;
        end

        if (branch.valid) begin
            if (branch.taken) begin
                pcs_n[branch.wid] = branch.dest;
            end
            stalled_n[branch.wid] = 1'b0;
        end

        // hold the picked warp until decode or a control event frees it
        if (pick_fire) begin
            stalled_n[pick_wid] = 1'b1;
        end

        if (accept_fire) begin
            pcs_n[accept_entry.wid] = accept_entry.pc + PC_STEP;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            active_q    <= wmask_t'(1);
            stalled_q   <= '0;
            spawn_valid <= 1'b0;
            for (int i = 0; i < NUM_WARPS; i++) begin
                tmasks_q[i] <= (i == 0) ? tmask_t'(1) : tmask_t'(0);
                pcs_q[i]    <= STARTUP_PC;
            end
        end else begin
            active_q  <= active_n;
            stalled_q <= stalled_n;
            tmasks_q  <= tmasks_n;
            pcs_q     <= pcs_n;
            if (spawn_apply) begin
                spawn_valid <= 1'b0;
            end
            if (spawn_capture) begin
                spawn_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (spawn_capture) begin
            spawn_wmask <= warp_ctl.wspawn.wmask;
            spawn_pc    <= warp_ctl.wspawn.pc;
            spawn_wid   <= warp_ctl.wid;
        end
    end

    assign active_warps = active_q;
    assign ready_warps  = active_q & ~stalled_q;
    assign all_tmasks   = tmasks_q;
    assign all_pcs      = pcs_q;

endmodule

`default_nettype wire
